//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= lsu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/data_memory.sv
`default_nettype none

module data_memory import lsu_pkg::*; (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,
    input  wire load_request_t load_request_i,
    output load_response_t     load_response_o,
    input  wire mem_write_t    mem_write_i,
    output logic               write_done_o
);

    data_word_t mem_q [DMEM_WORDS];

    logic [MEM_LATENCY-1:0] valid_pipe_q;
    data_word_t             data_pipe_q [MEM_LATENCY];

    dmem_index_t read_index;
    dmem_index_t write_index;

    assign read_index = load_request_i.address[9:2];
    assign write_index = mem_write_i.entry.address[9:2];

    // Loads own the single port and a pending store only goes in a free cycle
    assign write_done_o = mem_write_i.valid && !load_request_i.request;

    // ----------------------------------------------------------
    // Read pipeline
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe_q <= '0;
        end else begin
            valid_pipe_q <= {valid_pipe_q[MEM_LATENCY-2:0], load_request_i.request};
        end
    end

    always_ff @(posedge clk_i) begin
        data_pipe_q[0] <= mem_q[read_index];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe_q[i] <= data_pipe_q[i-1];
        end

        if (write_done_o) begin
            mem_q[write_index] <= mem_write_i.entry.data;
        end
    end

    assign load_response_o.valid = valid_pipe_q[MEM_LATENCY-1];
    assign load_response_o.data = data_pipe_q[MEM_LATENCY-1];

    a_write_yields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_done_o |-> !load_request_i.request);

endmodule : data_memory

`default_nettype wire

//--- logic/load_unit.sv
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           valid_operation_i,
    input  wire address_t       load_address_i,
    input  wire ldu_uop_t       operation_i,
    input  wire data_word_t     timer_data_i,
    output load_request_t       load_request_o,
    input  wire load_response_t load_response_i,
    input  wire logic           stu_address_match_i,
    input  wire data_word_t     stu_forwarded_data_i,
    input  wire logic           stb_address_match_i,
    input  wire data_word_t     stb_forwarded_data_i,
    output data_word_t          data_loaded_o,
    output logic                data_valid_o,
    output logic                idle_o,
    output logic                cachable_o
);

    typedef enum logic {
        IDLE,
        WAIT
    } load_state_e;

    load_state_e state_q;
    ldu_uop_t    operation_q;
    address_t    address_q;
    data_word_t  forwarded_q;
    logic        match_q;
    logic        cachable_q;

    logic       timer_access;
    logic       cachable;
    logic       forward_hit;
    data_word_t forward_word;
    logic       done;
    logic       accept;
    data_word_t data_selected;
    data_word_t data_sliced;

    // ----------------------------------------------------------
    // Address decode and forwarding priority
    // ----------------------------------------------------------

    assign timer_access = (load_address_i >= TIMER_START) && (load_address_i < TIMER_END);
    assign cachable = load_address_i > IO_END;

    // The store unit holds the youngest store, so it wins over the buffer
    assign forward_hit = stu_address_match_i | stb_address_match_i | timer_access;

    always_comb begin
        if (stu_address_match_i) begin
            forward_word = stu_forwarded_data_i;
        end else if (stb_address_match_i) begin
            forward_word = stb_forwarded_data_i;
        end else begin
            forward_word = timer_data_i;
        end
    end

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------

    // A forwarded word completes one cycle after the operation,
    // a memory load completes when the response comes back
    assign done = (state_q == WAIT) && (match_q || load_response_i.valid);

    // A new operation may also arrive in the cycle that completes the previous one
    assign accept = valid_operation_i && ((state_q == IDLE) || done);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            match_q <= 1'b0;
        end else if (accept) begin
            state_q <= WAIT;
            match_q <= forward_hit;
        end else if (done) begin
            state_q <= IDLE;
            match_q <= 1'b0;
        end
    end

    // Operation, address and forwarded word of the load in flight
    always_ff @(posedge clk_i) begin
        if (accept) begin
            operation_q <= operation_i;
            address_q <= load_address_i;
            forwarded_q <= forward_word;
            cachable_q <= cachable;
        end
    end

    // Only a miss goes to the data memory
    assign load_request_o.request = accept && !forward_hit;
    assign load_request_o.address = load_address_i;

    // Idle stays high through a forwarding hit so the next load can follow at once
    assign idle_o = ((state_q == IDLE) || done) && !(valid_operation_i && !forward_hit);

    assign cachable_o = (state_q == IDLE) ? cachable : cachable_q;

    // ----------------------------------------------------------
    // Result slicing
    // ----------------------------------------------------------

    assign data_selected = match_q ? forwarded_q : load_response_i.data;

    always_comb begin : slice
        logic [7:0]  byte_sel;
        logic [15:0] half_sel;

        byte_sel = data_selected[{address_q[1:0], 3'b000} +: 8];
        half_sel = data_selected[{address_q[1], 4'b0000} +: 16];

        case (operation_q.uop)
            LDB: begin
                if (operation_q.signed_load) begin
                    data_sliced = {{24{byte_sel[7]}}, byte_sel};
                end else begin
                    data_sliced = {24'b0, byte_sel};
                end
            end

            LDH: begin
                if (operation_q.signed_load) begin
                    data_sliced = {{16{half_sel[15]}}, half_sel};
                end else begin
                    data_sliced = {16'b0, half_sel};
                end
            end

            // Whole words pass unchanged
            default: begin
                data_sliced = data_selected;
            end
        endcase
    end

    assign data_loaded_o = data_sliced;
    assign data_valid_o = done;

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    a_half_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_operation_i && operation_i.uop == LDH) |-> !load_address_i[0]);

    a_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_operation_i && operation_i.uop == LDW) |-> load_address_i[1:0] == 2'b00);

    // The issuer must not send a load while one is still outstanding
    a_no_op_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_operation_i |-> (state_q == IDLE) || done);

endmodule : load_unit

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------

    typedef logic [31:0] data_word_t;
    typedef logic [31:0] address_t;

    // Word index into the data memory, taken from address bits 9 to 2
    typedef logic [7:0] dmem_index_t;

    // ----------------------------------------------------------
    // Memory map and sizes
    // ----------------------------------------------------------

    // Low timer word, the high word follows four bytes above
    localparam address_t TIMER_START = 32'h0000_0100;
    localparam address_t TIMER_END = 32'h0000_0108;

    // Everything above the IO region is cachable RAM
    localparam address_t IO_END = 32'h0000_0FFF;
    localparam address_t RAM_START = 32'h0000_1000;

    localparam int DMEM_WORDS = 256;
    localparam int MEM_LATENCY = 2;
    localparam int STB_DEPTH = 4;

    // Pointer width of the store buffer, its count is one bit wider
    localparam int STB_PTR_W = $clog2(STB_DEPTH);

    // ----------------------------------------------------------
    // Operations and channels
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        LDB,
        LDH,
        LDW
    } ldu_uop_e;

    typedef struct packed {
        ldu_uop_e uop;
        logic     signed_load;
    } ldu_uop_t;

    typedef struct packed {
        address_t   address;
        data_word_t data;
    } store_entry_t;

    typedef struct packed {
        logic     request;
        address_t address;
    } load_request_t;

    typedef struct packed {
        logic       valid;
        data_word_t data;
    } load_response_t;

    typedef struct packed {
        logic         valid;
        store_entry_t entry;
    } mem_write_t;

endpackage : lsu_pkg

`default_nettype wire

//--- logic/lsu_top.sv
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       load_valid_i,
    input  wire address_t   load_address_i,
    input  wire ldu_uop_t   load_op_i,
    output data_word_t      load_data_o,
    output logic            load_data_valid_o,
    output logic            load_idle_o,
    output logic            load_cachable_o,
    input  wire logic       store_valid_i,
    input  wire address_t   store_address_i,
    input  wire data_word_t store_data_i,
    output logic            store_idle_o
);

    // Load side
    load_request_t  load_request;
    load_response_t load_response;
    data_word_t     timer_data;

    // Forwarding from both store stages
    logic       stu_match;
    data_word_t stu_data;
    logic       stb_match;
    data_word_t stb_data;

    // Store side
    logic         push;
    store_entry_t push_entry;
    logic         stb_full;
    mem_write_t   mem_write;
    logic         write_done;

    load_unit i_load_unit (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .valid_operation_i    (load_valid_i),
        .load_address_i       (load_address_i),
        .operation_i          (load_op_i),
        .timer_data_i         (timer_data),
        .load_request_o       (load_request),
        .load_response_i      (load_response),
        .stu_address_match_i  (stu_match),
        .stu_forwarded_data_i (stu_data),
        .stb_address_match_i  (stb_match),
        .stb_forwarded_data_i (stb_data),
        .data_loaded_o        (load_data_o),
        .data_valid_o         (load_data_valid_o),
        .idle_o               (load_idle_o),
        .cachable_o           (load_cachable_o)
    );

    store_unit i_store_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .store_valid_i    (store_valid_i),
        .store_address_i  (store_address_i),
        .store_data_i     (store_data_i),
        .load_address_i   (load_address_i),
        .stb_full_i       (stb_full),
        .push_o           (push),
        .push_entry_o     (push_entry),
        .address_match_o  (stu_match),
        .forwarded_data_o (stu_data),
        .idle_o           (store_idle_o)
    );

    store_buffer i_store_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .push_i           (push),
        .push_entry_i     (push_entry),
        .full_o           (stb_full),
        .load_address_i   (load_address_i),
        .address_match_o  (stb_match),
        .forwarded_data_o (stb_data),
        .mem_write_o      (mem_write),
        .write_done_i     (write_done)
    );

    // Address bit 2 separates the low and high timer words
    mmio_timer i_mmio_timer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .select_high_i (load_address_i[2]),
        .timer_data_o  (timer_data)
    );

    data_memory i_data_memory (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .load_request_i  (load_request),
        .load_response_o (load_response),
        .mem_write_i     (mem_write),
        .write_done_o    (write_done)
    );

endmodule : lsu_top

`default_nettype wire

//--- logic/mmio_timer.sv
`default_nettype none

module mmio_timer import lsu_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic select_high_i,
    output data_word_t timer_data_o
);

    logic [63:0] count_q;

    // Free running cycle counter, zero in the first cycle out of reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 64'd1;
        end
    end

    // Address bit 2 picks the word
    assign timer_data_o = select_high_i ? count_q[63:32] : count_q[31:0];

endmodule : mmio_timer

`default_nettype wire

//--- logic/store_buffer.sv
`default_nettype none

module store_buffer import lsu_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         push_i,
    input  wire store_entry_t push_entry_i,
    output logic              full_o,
    input  wire address_t     load_address_i,
    output logic              address_match_o,
    output data_word_t        forwarded_data_o,
    output mem_write_t        mem_write_o,
    input  wire logic         write_done_i
);

    store_entry_t fifo_q [STB_DEPTH];

    logic [STB_PTR_W-1:0] rd_ptr_q;
    logic [STB_PTR_W-1:0] wr_ptr_q;
    logic [STB_PTR_W:0]   count_q;

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------

    // The depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (write_done_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({push_i, write_done_i})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            fifo_q[wr_ptr_q] <= push_entry_i;
        end
    end

    assign full_o = (count_q == (STB_PTR_W + 1)'(STB_DEPTH));

    // The oldest entry is offered to the memory while anything is pending
    assign mem_write_o.valid = (count_q != '0);
    assign mem_write_o.entry = fifo_q[rd_ptr_q];

    // ----------------------------------------------------------
    // Forwarding search
    // ----------------------------------------------------------

    // Entries are scanned from oldest to youngest, so a later hit overrides
    always_comb begin : forward_search
        logic [STB_PTR_W-1:0] idx;

        idx = rd_ptr_q;
        address_match_o = 1'b0;
        forwarded_data_o = '0;

        for (int i = 0; i < STB_DEPTH; i++) begin
            idx = rd_ptr_q + STB_PTR_W'(i);
            if ((i < int'(count_q)) &&
                (fifo_q[idx].address[31:2] == load_address_i[31:2])) begin
                address_match_o = 1'b1;
                forwarded_data_o = fifo_q[idx].data;
            end
        end
    end

    a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o);

    // The memory only acknowledges a write the buffer actually offered
    a_done_needs_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_done_i |-> mem_write_o.valid);

endmodule : store_buffer

`default_nettype wire

//--- logic/store_unit.sv
`default_nettype none

module store_unit import lsu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       store_valid_i,
    input  wire address_t   store_address_i,
    input  wire data_word_t store_data_i,
    input  wire address_t   load_address_i,
    input  wire logic       stb_full_i,
    output logic            push_o,
    output store_entry_t    push_entry_o,
    output logic            address_match_o,
    output data_word_t      forwarded_data_o,
    output logic            idle_o
);

    logic         busy_q;
    store_entry_t entry_q;

    // The held store leaves as soon as the buffer has room
    assign push_o = busy_q && !stb_full_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (store_valid_i) begin
            busy_q <= 1'b1;
        end else if (push_o) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (store_valid_i) begin
            entry_q.address <= store_address_i;
            entry_q.data <= store_data_i;
        end
    end

    assign push_entry_o = entry_q;
    assign idle_o = !busy_q;

    // Stores are whole words, so a word address match forwards the full word
    assign address_match_o = busy_q && (entry_q.address[31:2] == load_address_i[31:2]);
    assign forwarded_data_o = entry_q.data;

    a_no_store_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_valid_i |-> !busy_q);

    a_store_in_ram: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_valid_i |-> (store_address_i >= RAM_START) && (store_address_i[1:0] == 2'b00));

endmodule : store_unit

`default_nettype wire

//--- test/lsu_tb.sv
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SEED = 32'h550d_8ce9;
    localparam int RESET_CYCLES = 16;
    // A small window so that store and load addresses collide often
    localparam int WINDOW_WORDS = 16;
    localparam int RANDOM_OPS = 2000;
    localparam int BURST_STORES = 5;
    localparam int READY_TIMEOUT = 64;
    localparam int TRAFFIC_TIMEOUT = 20000;
    localparam int BURST_TIMEOUT = 200;

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    logic       load_valid_i;
    address_t   load_address_i;
    ldu_uop_t   load_op_i;
    data_word_t load_data_o;
    logic       load_data_valid_o;
    logic       load_idle_o;
    logic       load_cachable_o;
    logic       store_valid_i;
    address_t   store_address_i;
    data_word_t store_data_i;
    logic       store_idle_o;

    // Reference model state, indexed by word address
    data_word_t  model_mem [logic [29:0]];
    logic [29:0] model_stb [$];
    logic        model_stu_busy;
    logic [29:0] model_stu_word;
    // Cycles until the outstanding load returns, 1 means this cycle, 0 means none
    int          load_wait;
    data_word_t  exp_data;
    logic        exp_cachable;
    logic [63:0] cycle_count;

    always #2 clk_i = ~clk_i;

    lsu_top i_dut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .load_valid_i      (load_valid_i),
        .load_address_i    (load_address_i),
        .load_op_i         (load_op_i),
        .load_data_o       (load_data_o),
        .load_data_valid_o (load_data_valid_o),
        .load_idle_o       (load_idle_o),
        .load_cachable_o   (load_cachable_o),
        .store_valid_i     (store_valid_i),
        .store_address_i   (store_address_i),
        .store_data_i      (store_data_i),
        .store_idle_o      (store_idle_o)
    );

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    task automatic compare_word(string name, data_word_t actual, data_word_t expected);
        if (actual !== expected) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic compare_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "Flag mismatch on %s", name);
        end
    endtask

    task automatic compare_idle(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "Idle mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(string what, int limit);
        $display("At %0t the testbench gave up: %s within %0d cycles", $time, what, limit);
        $display("sim failed");
        $fatal(1, "Timeout");
    endtask

    // ----------------------------------------------------------
    // Model rules
    // ----------------------------------------------------------

    function automatic logic in_timer(address_t addr);
        return (addr >= TIMER_START) && (addr < TIMER_END);
    endfunction

    // True when the load is answered from a store stage or the timer
    function automatic logic served_without_memory(address_t addr);
        logic hit;
        hit = in_timer(addr) || (model_stu_busy && (model_stu_word == addr[31:2]));
        foreach (model_stb[i]) begin
            if (model_stb[i] == addr[31:2]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Shift the wanted byte or half word down, then extend it
    function automatic data_word_t expected_slice(data_word_t word, logic [1:0] offset,
                                                  ldu_uop_t op);
        data_word_t shifted;
        data_word_t result;
        shifted = word >> (int'(offset) * 8);
        result = word;
        if (op.uop == LDB) begin
            if (op.signed_load) begin
                result = {{24{shifted[7]}}, shifted[7:0]};
            end else begin
                result = {24'h00_0000, shifted[7:0]};
            end
        end else if (op.uop == LDH) begin
            if (op.signed_load) begin
                result = {{16{shifted[15]}}, shifted[15:0]};
            end else begin
                result = {16'h0000, shifted[15:0]};
            end
        end
        return result;
    endfunction

    function automatic address_t window_address(int index);
        return RAM_START + 32'(index * 4);
    endfunction

    // Initial contents mix every address bit
    function automatic data_word_t fill_pattern(address_t addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]} ^ 32'h3C5A_0F96;
    endfunction

    // ----------------------------------------------------------
    // One clock cycle of stimulus, checks and model update
    // ----------------------------------------------------------

    task automatic run_cycle(input logic ld_v, input address_t ld_addr, input ldu_uop_t ld_op,
                             input logic st_v, input address_t st_addr,
                             input data_word_t st_data);
        logic       hit;
        logic       request;
        logic       write_done;
        logic       push;
        data_word_t word;

        @(posedge clk_i);
        load_valid_i <= ld_v;
        load_address_i <= ld_addr;
        load_op_i <= ld_op;
        store_valid_i <= st_v;
        store_address_i <= st_addr;
        store_data_i <= st_data;

        // Outputs are settled by the falling edge
        @(negedge clk_i);
        hit = ld_v && served_without_memory(ld_addr);
        request = ld_v && !hit;

        compare_idle("store_idle_o", store_idle_o, !model_stu_busy);
        compare_idle("load_idle_o", load_idle_o, (load_wait <= 1) && !request);
        compare_flag("load_data_valid_o", load_data_valid_o, load_wait == 1);
        if (load_wait == 1) begin
            compare_word("load_data_o", load_data_o, exp_data);
            compare_flag("load_cachable_o", load_cachable_o, exp_cachable);
        end

        // The memory port takes a buffered store only in a cycle without a request
        write_done = (model_stb.size() != 0) && !request;
        push = model_stu_busy && (model_stb.size() < STB_DEPTH);
        if (write_done) begin
            void'(model_stb.pop_front());
        end
        if (push) begin
            model_stb.push_back(model_stu_word);
            model_stu_busy = 1'b0;
        end

        if (ld_v) begin
            if (in_timer(ld_addr)) begin
                word = ld_addr[2] ? cycle_count[63:32] : cycle_count[31:0];
            end else begin
                word = model_mem[ld_addr[31:2]];
            end
            exp_data = expected_slice(word, ld_addr[1:0], ld_op);
            exp_cachable = ld_addr > IO_END;
            load_wait = hit ? 1 : MEM_LATENCY;
        end else if (load_wait > 0) begin
            load_wait--;
        end

        if (st_v) begin
            model_mem[st_addr[31:2]] = st_data;
            model_stu_busy = 1'b1;
            model_stu_word = st_addr[31:2];
        end

        cycle_count = cycle_count + 64'd1;
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic load_cycle(address_t addr, ldu_uop_t op);
        run_cycle(1'b1, addr, op, 1'b0, '0, '0);
    endtask

    task automatic store_cycle(address_t addr, data_word_t data);
        run_cycle(1'b0, '0, '0, 1'b1, addr, data);
    endtask

    // ----------------------------------------------------------
    // Random choices
    // ----------------------------------------------------------

    task automatic pick_op(output ldu_uop_t op, output logic [1:0] offset);
        op.uop = ldu_uop_e'($urandom_range(0, 2));
        op.signed_load = 1'($urandom_range(0, 1));
        case (op.uop)
            LDB: offset = 2'($urandom_range(0, 3));
            LDH: offset = {1'($urandom_range(0, 1)), 1'b0};
            default: offset = 2'b00;
        endcase
    endtask

    task automatic pick_load(input logic ram_only, output address_t addr, output ldu_uop_t op);
        logic [1:0] offset;
        pick_op(op, offset);
        if (!ram_only && ($urandom_range(0, 7) == 0)) begin
            addr = TIMER_START + 32'($urandom_range(0, 1) * 4);
        end else begin
            addr = window_address(int'($urandom_range(0, WINDOW_WORDS - 1)));
        end
        addr[1:0] = offset;
    endtask

    // ----------------------------------------------------------
    // Waits
    // ----------------------------------------------------------

    task automatic wait_load_ready();
        int waited;
        waited = 0;
        while (load_wait > 1) begin
            if (waited == READY_TIMEOUT) begin
                report_timeout("load_idle_o did not return high", READY_TIMEOUT);
            end
            idle_cycle();
            waited++;
        end
    endtask

    task automatic wait_store_ready();
        int waited;
        waited = 0;
        while (model_stu_busy) begin
            if (waited == READY_TIMEOUT) begin
                report_timeout("store_idle_o did not return high", READY_TIMEOUT);
            end
            idle_cycle();
            waited++;
        end
    endtask

    // Lets the last load return and every store reach the data memory
    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((load_wait != 0) || model_stu_busy || (model_stb.size() != 0)) begin
            if (waited == READY_TIMEOUT) begin
                report_timeout("the load and store paths did not drain", READY_TIMEOUT);
            end
            idle_cycle();
            waited++;
        end
    endtask

    // ----------------------------------------------------------
    // Test phases
    // ----------------------------------------------------------

    task automatic reset_dut();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk_i);
        end
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        compare_flag("load_data_valid_o", load_data_valid_o, 1'b0);
        compare_idle("load_idle_o", load_idle_o, 1'b1);
        compare_idle("store_idle_o", store_idle_o, 1'b1);
        // The timer reads zero in this first cycle
        cycle_count = 64'd1;
    endtask

    task automatic fill_window();
        address_t addr;
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            wait_store_ready();
            addr = window_address(w);
            store_cycle(addr, fill_pattern(addr));
        end
    endtask

    task automatic random_traffic();
        int          ops;
        int          cycles;
        int unsigned pick;
        address_t    addr;
        ldu_uop_t    op;
        ops = 0;
        cycles = 0;
        while (ops < RANDOM_OPS) begin
            if (cycles == TRAFFIC_TIMEOUT) begin
                report_timeout("the random operations were not all issued", TRAFFIC_TIMEOUT);
            end
            pick = $urandom_range(0, 9);
            if ((pick < 5) && (load_wait <= 1)) begin
                pick_load(1'b0, addr, op);
                load_cycle(addr, op);
                ops++;
            end else if ((pick < 9) && !model_stu_busy) begin
                addr = window_address(int'($urandom_range(0, WINDOW_WORDS - 1)));
                store_cycle(addr, $urandom());
                ops++;
            end else begin
                idle_cycle();
            end
            cycles++;
        end
    endtask

    // Loads take every slot they can and stores fill the gaps in between
    task automatic load_burst_with_stores();
        int       cycles;
        int       stores;
        logic     saw_low;
        address_t addr;
        ldu_uop_t op;
        cycles = 0;
        stores = 0;
        saw_low = 1'b0;
        while (!(saw_low && (stores >= BURST_STORES))) begin
            if (cycles == BURST_TIMEOUT) begin
                report_timeout("store_idle_o did not go low under the load burst",
                               BURST_TIMEOUT);
            end
            if (load_wait <= 1) begin
                pick_load(1'b1, addr, op);
                load_cycle(addr, op);
            end else if (!model_stu_busy) begin
                addr = window_address(int'($urandom_range(0, WINDOW_WORDS - 1)));
                store_cycle(addr, $urandom());
                stores++;
            end else begin
                idle_cycle();
            end
            if (!store_idle_o) begin
                saw_low = 1'b1;
            end
            cycles++;
        end
    endtask

    // Every word is read back from the data memory itself
    task automatic verify_window();
        address_t   addr;
        ldu_uop_t   op;
        logic [1:0] offset;
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            wait_load_ready();
            pick_op(op, offset);
            addr = window_address(w);
            addr[1:0] = offset;
            load_cycle(addr, op);
        end
        wait_drained();
    endtask

    initial begin
        int unsigned seed_value;

        seed_value = $urandom(SEED);

        rst_n_i = 1'b0;
        load_valid_i = 1'b0;
        load_address_i = '0;
        load_op_i = '0;
        store_valid_i = 1'b0;
        store_address_i = '0;
        store_data_i = '0;

        model_stb.delete();
        model_stu_busy = 1'b0;
        model_stu_word = '0;
        load_wait = 0;
        exp_data = '0;
        exp_cachable = 1'b0;
        cycle_count = 64'd0;

        reset_dut();
        fill_window();
        random_traffic();
        load_burst_with_stores();
        wait_drained();
        verify_window();

        $display("sim passed");
        $finish;
    end

endmodule : lsu_tb

`default_nettype wire

//--- vlog.f
logic/lsu_pkg.sv
logic/load_unit.sv
logic/store_unit.sv
logic/store_buffer.sv
logic/mmio_timer.sv
logic/data_memory.sv
logic/lsu_top.sv
test/lsu_tb.sv
